// ==== cpu_config.svh ====
`default_nettype none
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// datapath width, also the width of byte addresses and pc
`define CPU_XLEN 16

// architectural registers
// r0 always reads as zero
`define CPU_NREGS 16

// instruction memory depth as word-address bits
// 256 words of 16 bits
`define CPU_IMEM_AW 8

// data memory depth as word-address bits
`define CPU_DMEM_AW 8

`endif
`default_nettype wire

// ==== cpu_pkg.sv ====
`include "cpu_config.svh"
`default_nettype none

package cpu_pkg;

	// one data word, also used for byte addresses
	typedef logic [`CPU_XLEN-1:0] data_t;

	// register number
	typedef logic [$clog2(`CPU_NREGS)-1:0] reg_idx_t;

	// encoding order is fixed, alu ops occupy 0..7
	typedef enum logic [3:0] {
		OP_ADD = 4'h0,
		OP_SUB = 4'h1,
		OP_XOR = 4'h2,
		OP_AND = 4'h3,
		OP_SLL = 4'h4,
		OP_SRA = 4'h5,
		OP_ROR = 4'h6,
		OP_OR  = 4'h7,
		OP_LW  = 4'h8,
		OP_SW  = 4'h9,
		OP_LHB = 4'ha,
		OP_LLB = 4'hb,
		OP_B   = 4'hc,
		OP_BR  = 4'hd,
		OP_PCS = 4'he,
		OP_HLT = 4'hf
	} opcode_e;

	// branch condition, held in instr[11:9] of B and BR
	typedef enum logic [2:0] {
		COND_NE = 3'd0,
		COND_EQ = 3'd1,
		COND_GT = 3'd2,
		COND_LT = 3'd3,
		COND_GE = 3'd4,
		COND_LE = 3'd5,
		COND_OV = 3'd6,
		COND_AL = 3'd7
	} cond_e;

	// generic r-type view
	// byte immediates, offsets and conditions overlay the low fields
	typedef struct packed {
		opcode_e  op;
		reg_idx_t rd;
		reg_idx_t rs;
		reg_idx_t rt;
	} instr_t;

	typedef struct packed {
		logic z;
		logic v;
		logic n;
	} flags_t;

	// decoder output
	typedef struct packed {
		logic    reg_write;
		logic    alu_src_imm;
		logic    mem_write;
		logic    mem_to_reg;
		logic    byte_load;
		logic    byte_high;
		logic    pcs;
		logic    branch;
		logic    branch_reg;
		logic    halt;
		opcode_e alu_op;
	} ctrl_t;

	// one record per retired instruction
	typedef struct packed {
		logic     valid;
		data_t    pc;
		logic     reg_write;
		reg_idx_t rd;
		data_t    wdata;
		logic     mem_write;
		data_t    mem_addr;
		data_t    mem_wdata;
	} retire_t;

endpackage

`default_nettype wire

// ==== word_mem.sv ====
`timescale 1ns/10ps
`include "cpu_config.svh"
`default_nettype none

module word_mem #(
	parameter type word_t       = logic [`CPU_XLEN-1:0],
	parameter int  AW           = `CPU_DMEM_AW,
	parameter bit  CLEAR_ON_RST = 1'b1
) (
	input  wire          clk,
	input  wire          rst,
	input  wire          we,
	input  wire [AW-1:0] waddr,
	input  wire word_t   wdata,
	input  wire [AW-1:0] raddr,
	output word_t        rdata
);

	// 2^AW words
	word_t mem [2**AW];

	// read is combinational, part of the single-cycle path
	assign rdata = mem[raddr];

	// clear only where asked, so the program image survives reset
	always_ff @(posedge clk) begin
		if (CLEAR_ON_RST && rst) begin
			for (int i = 0; i < 2**AW; i++) begin
				mem[i] <= word_t'('0);
			end
		end else if (we) begin
			mem[waddr] <= wdata;
		end
	end

endmodule

`default_nettype wire

// ==== reg_file.sv ====
`timescale 1ns/10ps
`include "cpu_config.svh"
`default_nettype none

module reg_file (
	input  wire                    clk,
	input  wire                    rst,
	input  wire cpu_pkg::reg_idx_t ra,
	input  wire cpu_pkg::reg_idx_t rb,
	input  wire cpu_pkg::reg_idx_t rw,
	input  wire                    we,
	input  wire cpu_pkg::data_t    wdata,
	output cpu_pkg::data_t         da,
	output cpu_pkg::data_t         db
);

	cpu_pkg::data_t regs [`CPU_NREGS];

	// r0 is forced to zero on read, its storage is never written
	assign da = (ra == '0) ? '0 : regs[ra];
	assign db = (rb == '0) ? '0 : regs[rb];

	// write at the end of the cycle
	// a read of rw in the same cycle still sees the old value
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `CPU_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we && rw != '0) begin
			regs[rw] <= wdata;
		end
	end

endmodule

`default_nettype wire

// ==== alu.sv ====
`timescale 1ns/10ps
`include "cpu_config.svh"
`default_nettype none

module alu (
	input  wire cpu_pkg::data_t   a,
	input  wire cpu_pkg::data_t   b,
	input  wire cpu_pkg::opcode_e op,
	output cpu_pkg::data_t        result,
	output cpu_pkg::flags_t       flags,
	output logic [2:0]            flag_we
);

	localparam int SHW = $clog2(`CPU_XLEN);

	// shift and rotate amount from the low bits of b
	logic [SHW-1:0] sh;
	logic [2*`CPU_XLEN-1:0] rot;
	logic ovf;

	assign sh = b[SHW-1:0];
	// rotate right by shifting a doubled copy
	assign rot = {a, a} >> sh;

	always_comb begin
		ovf = 1'b0;
		case (op)
			cpu_pkg::OP_ADD: begin
				result = a + b;
				// same-sign operands giving a different-sign sum
				ovf = (a[`CPU_XLEN-1] == b[`CPU_XLEN-1]) &&
					(result[`CPU_XLEN-1] != a[`CPU_XLEN-1]);
			end
			cpu_pkg::OP_SUB: begin
				result = a - b;
				ovf = (a[`CPU_XLEN-1] != b[`CPU_XLEN-1]) &&
					(result[`CPU_XLEN-1] != a[`CPU_XLEN-1]);
			end
			cpu_pkg::OP_XOR: result = a ^ b;
			cpu_pkg::OP_AND: result = a & b;
			cpu_pkg::OP_SLL: result = a << sh;
			cpu_pkg::OP_SRA: result = $signed(a) >>> sh;
			cpu_pkg::OP_ROR: result = rot[`CPU_XLEN-1:0];
			cpu_pkg::OP_OR:  result = a | b;
			// non-alu opcodes, used for the lw/sw address
			default: result = a + b;
		endcase
	end

	always_comb begin
		flags.z = (result == '0);
		flags.v = ovf;
		flags.n = result[`CPU_XLEN-1];
	end

	// z for all eight alu ops, v and n for add and sub only
	// order matches flags_t: z, v, n
	always_comb begin
		flag_we = 3'b000;
		if (!op[3]) begin
			flag_we[2] = 1'b1;
		end
		if (op == cpu_pkg::OP_ADD || op == cpu_pkg::OP_SUB) begin
			flag_we[1:0] = 2'b11;
		end
	end

endmodule

`default_nettype wire

// ==== pc_unit.sv ====
`timescale 1ns/10ps
`include "cpu_config.svh"
`default_nettype none

module pc_unit (
	input  wire                  clk,
	input  wire                  rst,
	input  wire cpu_pkg::ctrl_t  ctrl,
	input  wire cpu_pkg::cond_e  cond,
	input  wire [8:0]            offset,
	input  wire cpu_pkg::data_t  target,
	input  wire cpu_pkg::flags_t new_flags,
	input  wire [2:0]            flag_we,
	output cpu_pkg::data_t       pc,
	output cpu_pkg::data_t       pc_next2,
	output logic                 hlt
);

	cpu_pkg::flags_t flags_q;
	cpu_pkg::data_t  br_target;
	cpu_pkg::data_t  pc_next;
	logic            halted_q;
	logic            hold;
	logic            taken;

	// condition against the flags of earlier instructions only
	always_comb begin
		case (cond)
			cpu_pkg::COND_NE: taken = !flags_q.z;
			cpu_pkg::COND_EQ: taken = flags_q.z;
			cpu_pkg::COND_GT: taken = !flags_q.z && !flags_q.n;
			cpu_pkg::COND_LT: taken = flags_q.n;
			cpu_pkg::COND_GE: taken = flags_q.z || !flags_q.n;
			cpu_pkg::COND_LE: taken = flags_q.z || flags_q.n;
			cpu_pkg::COND_OV: taken = flags_q.v;
			default:          taken = 1'b1;
		endcase
	end

	// sequential pc, also the pcs write value
	assign pc_next2 = pc + `CPU_XLEN'(2);
	// offset counts words, so scale by two
	assign br_target = pc_next2 + {{(`CPU_XLEN-10){offset[8]}}, offset, 1'b0};

	// hlt holds the pc from the cycle it is fetched
	assign hold = halted_q || ctrl.halt;

	always_comb begin
		if (hold)
			pc_next = pc;
		else if (ctrl.branch && taken)
			pc_next = br_target;
		else if (ctrl.branch_reg && taken)
			pc_next = target;
		else
			pc_next = pc_next2;
	end

	// kept low during reset even if pc 0 holds a stale hlt
	assign hlt = !rst && hold;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc       <= '0;
			flags_q  <= '0;
			halted_q <= 1'b0;
		end else begin
			pc       <= pc_next;
			halted_q <= hold;
			// each flag keeps its value unless its enable is set
			if (!halted_q) begin
				if (flag_we[2])
					flags_q.z <= new_flags.z;
				if (flag_we[1])
					flags_q.v <= new_flags.v;
				if (flag_we[0])
					flags_q.n <= new_flags.n;
			end
		end
	end

endmodule

`default_nettype wire

// ==== decoder.sv ====
`timescale 1ns/10ps
`include "cpu_config.svh"
`default_nettype none

module decoder (
	input  wire cpu_pkg::instr_t instr,
	output cpu_pkg::ctrl_t       ctrl,
	output cpu_pkg::reg_idx_t    src_a,
	output cpu_pkg::reg_idx_t    src_b,
	output cpu_pkg::data_t       imm
);

	always_comb begin
		ctrl = '0;
		// alu sees the raw opcode, it ignores flag writes above OP_OR
		ctrl.alu_op = instr.op;
		case (instr.op)
			cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_XOR,
			cpu_pkg::OP_AND, cpu_pkg::OP_OR: begin
				ctrl.reg_write = 1'b1;
			end
			// shift amount comes from the immediate field
			cpu_pkg::OP_SLL, cpu_pkg::OP_SRA, cpu_pkg::OP_ROR: begin
				ctrl.reg_write   = 1'b1;
				ctrl.alu_src_imm = 1'b1;
			end
			cpu_pkg::OP_LW: begin
				ctrl.reg_write   = 1'b1;
				ctrl.alu_src_imm = 1'b1;
				ctrl.mem_to_reg  = 1'b1;
			end
			cpu_pkg::OP_SW: begin
				ctrl.alu_src_imm = 1'b1;
				ctrl.mem_write   = 1'b1;
			end
			cpu_pkg::OP_LHB: begin
				ctrl.reg_write = 1'b1;
				ctrl.byte_load = 1'b1;
				ctrl.byte_high = 1'b1;
			end
			cpu_pkg::OP_LLB: begin
				ctrl.reg_write = 1'b1;
				ctrl.byte_load = 1'b1;
			end
			cpu_pkg::OP_B:   ctrl.branch = 1'b1;
			cpu_pkg::OP_BR:  ctrl.branch_reg = 1'b1;
			cpu_pkg::OP_PCS: begin
				ctrl.reg_write = 1'b1;
				ctrl.pcs       = 1'b1;
			end
			default: ctrl.halt = 1'b1;
		endcase
	end

	// byte loads merge into rd, so rd is read as the first source
	assign src_a = ctrl.byte_load ? instr.rd : instr.rs;
	// sw stores the register named in the rd field
	assign src_b = (instr.op == cpu_pkg::OP_SW) ? instr.rd : instr.rt;

	// 4-bit signed immediate from the rt field
	assign imm = {{(`CPU_XLEN-4){instr.rt[3]}}, instr.rt};

endmodule

`default_nettype wire

// ==== cpu.sv ====
`timescale 1ns/10ps
`include "cpu_config.svh"
`default_nettype none

module cpu (
	input  wire                  clk,
	input  wire                  rst,
	input  wire                  prog_we,
	input  wire cpu_pkg::data_t  prog_addr,
	input  wire cpu_pkg::instr_t prog_data,
	output cpu_pkg::data_t       pc,
	output logic                 hlt,
	output cpu_pkg::retire_t     retire
);

	cpu_pkg::instr_t   instr;
	cpu_pkg::ctrl_t    ctrl;
	cpu_pkg::reg_idx_t src_a;
	cpu_pkg::reg_idx_t src_b;
	cpu_pkg::data_t    imm;
	cpu_pkg::data_t    da;
	cpu_pkg::data_t    db;
	cpu_pkg::data_t    alu_b;
	cpu_pkg::data_t    alu_res;
	cpu_pkg::flags_t   alu_flags;
	logic [2:0]        flag_we;
	cpu_pkg::data_t    mem_rdata;
	cpu_pkg::data_t    pc_next2;
	cpu_pkg::data_t    byte_val;
	cpu_pkg::data_t    wb_data;
	cpu_pkg::cond_e    cond;
	logic [8:0]        offset;
	logic [7:0]        imm8;

	// program image, written only through the load port
	word_mem #(
		.word_t      (cpu_pkg::instr_t),
		.AW          (`CPU_IMEM_AW),
		.CLEAR_ON_RST(1'b0)
	) imem (
		.clk  (clk),
		.rst  (rst),
		.we   (prog_we),
		.waddr(prog_addr[`CPU_IMEM_AW:1]),
		.wdata(prog_data),
		.raddr(pc[`CPU_IMEM_AW:1]),
		.rdata(instr)
	);

	decoder u_decoder (
		.instr(instr),
		.ctrl (ctrl),
		.src_a(src_a),
		.src_b(src_b),
		.imm  (imm)
	);

	// b/br fields overlay rd, rs and rt
	assign cond   = cpu_pkg::cond_e'(instr.rd[3:1]);
	assign offset = {instr.rd[0], instr.rs, instr.rt};
	assign imm8   = {instr.rs, instr.rt};

	reg_file u_reg_file (
		.clk  (clk),
		.rst  (rst),
		.ra   (src_a),
		.rb   (src_b),
		.rw   (instr.rd),
		.we   (ctrl.reg_write),
		.wdata(wb_data),
		.da   (da),
		.db   (db)
	);

	// memory offsets count words, scale to a byte address
	always_comb begin
		if (!ctrl.alu_src_imm)
			alu_b = db;
		else if (ctrl.mem_write || ctrl.mem_to_reg)
			alu_b = {imm[`CPU_XLEN-2:0], 1'b0};
		else
			alu_b = imm;
	end

	alu u_alu (
		.a      (da),
		.b      (alu_b),
		.op     (ctrl.alu_op),
		.result (alu_res),
		.flags  (alu_flags),
		.flag_we(flag_we)
	);

	// data memory, addressed by the alu sum rs + offset*2
	word_mem #(
		.word_t      (cpu_pkg::data_t),
		.AW          (`CPU_DMEM_AW),
		.CLEAR_ON_RST(1'b1)
	) dmem (
		.clk  (clk),
		.rst  (rst),
		.we   (ctrl.mem_write),
		.waddr(alu_res[`CPU_DMEM_AW:1]),
		.wdata(db),
		.raddr(alu_res[`CPU_DMEM_AW:1]),
		.rdata(mem_rdata)
	);

	pc_unit u_pc_unit (
		.clk      (clk),
		.rst      (rst),
		.ctrl     (ctrl),
		.cond     (cond),
		.offset   (offset),
		.target   (da),
		.new_flags(alu_flags),
		.flag_we  (flag_we),
		.pc       (pc),
		.pc_next2 (pc_next2),
		.hlt      (hlt)
	);

	// lhb keeps the low byte of rd, llb keeps the high byte
	assign byte_val = ctrl.byte_high ? {imm8, da[7:0]} : {da[`CPU_XLEN-1:8], imm8};

	// write-back priority: pcs, load, byte merge, alu
	always_comb begin
		if (ctrl.pcs)
			wb_data = pc_next2;
		else if (ctrl.mem_to_reg)
			wb_data = mem_rdata;
		else if (ctrl.byte_load)
			wb_data = byte_val;
		else
			wb_data = alu_res;
	end

	// trace of the instruction at pc, none for hlt or during reset
	always_comb begin
		retire.valid     = !rst && !hlt;
		retire.pc        = pc;
		retire.reg_write = ctrl.reg_write;
		retire.rd        = instr.rd;
		retire.wdata     = wb_data;
		retire.mem_write = ctrl.mem_write;
		retire.mem_addr  = alu_res;
		retire.mem_wdata = db;
	end

endmodule

`default_nettype wire

// ==== cpu_clk_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module cpu_clk_gen #(
	parameter realtime PERIOD = 4.0
) (
	output logic clk
);

	// free-running clock, low for the first half period
	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2.0) clk = ~clk;
	end

endmodule

`default_nettype wire

// ==== cpu_sva.sv ====
`timescale 1ns/10ps
`default_nettype none

module cpu_sva (
	input wire                    clk,
	input wire                    rst,
	input wire cpu_pkg::data_t    pc,
	input wire                    hlt,
	input wire cpu_pkg::retire_t  retire,
	input wire cpu_pkg::instr_t   instr,
	input wire cpu_pkg::data_t    db
);

	// once halted the pc and hlt must not move until reset
	pc_holds_in_halt: assert property (@(posedge clk) disable iff (rst)
		hlt |=> (hlt && $stable(pc)))
		else $error("pc moved or hlt dropped while halted");

	// a fetched hlt halts at once and retires nothing
	no_retire_in_halt: assert property (@(posedge clk) disable iff (rst)
		(instr.op == cpu_pkg::OP_HLT) |-> (hlt && !retire.valid))
		else $error("hlt fetched but core did not halt or still retired");

	// r0 reads zero whatever was retired to it before
	// so r0 combined with x by add, or or xor must give x
	r0_reads_zero: assert property (@(posedge clk) disable iff (rst)
		(retire.valid && instr.rs == '0 &&
			instr.op inside {cpu_pkg::OP_ADD, cpu_pkg::OP_OR, cpu_pkg::OP_XOR})
		|-> (retire.wdata == db))
		else $error("register r0 read back nonzero");

endmodule

bind cpu cpu_sva u_sva (
	.clk   (clk),
	.rst   (rst),
	.pc    (pc),
	.hlt   (hlt),
	.retire(retire),
	.instr (instr),
	.db    (db)
);

`default_nettype wire

// ==== cpu_tb.sv ====
`timescale 1ns/10ps
`include "cpu_config.svh"
`default_nettype none

module cpu_tb;

	localparam int TIMEOUT = 20;
	localparam int MAX_STEPS = 200;
	localparam int HALT_WINDOW = 10;

	wire                clk;
	logic               rst;
	logic               prog_we;
	cpu_pkg::data_t     prog_addr;
	cpu_pkg::instr_t    prog_data;
	cpu_pkg::data_t     pc;
	logic               hlt;
	cpu_pkg::retire_t   retire;

	// program table, one instruction word and one note per row
	logic [15:0] prog_q[$];
	string       note_q[$];
	logic [31:0] rng;
	int          errors;

	// reference model state
	logic [15:0] m_regs [`CPU_NREGS];
	logic [15:0] m_mem [2**`CPU_DMEM_AW];
	logic [15:0] m_pc;
	logic        mz;
	logic        mv;
	logic        mn;

	cpu_clk_gen #(.PERIOD(4.0)) u_clk (.clk(clk));

	cpu UUT (
		.clk      (clk),
		.rst      (rst),
		.prog_we  (prog_we),
		.prog_addr(prog_addr),
		.prog_data(prog_data),
		.pc       (pc),
		.hlt      (hlt),
		.retire   (retire)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	function automatic logic [15:0] enc(input logic [3:0] op, input logic [3:0] a,
			input logic [3:0] b, input logic [3:0] c);
		return {op, a, b, c};
	endfunction

	task automatic add_row(input logic [15:0] w, input string note);
		prog_q.push_back(w);
		note_q.push_back(note);
	endtask

	// byte load with a pseudo-random immediate
	task automatic add_rnd_byte(input logic [3:0] op, input logic [3:0] rd);
		rng = xorshift(rng);
		add_row(enc(op, rd, rng[7:4], rng[3:0]), "random byte load");
	endtask

	// llb then lhb gives a full 16-bit constant
	task automatic set_reg(input logic [3:0] rd, input logic [15:0] v);
		add_row(enc(4'hb, rd, v[7:4], v[3:0]), "llb constant");
		add_row(enc(4'ha, rd, v[15:12], v[11:8]), "lhb constant");
	endtask

	// skip one pcs marker when taken, pcs leaves the flags alone
	task automatic add_branch(input logic [2:0] cond, input string note);
		add_row({4'hc, cond, 9'd1}, note);
		add_row(enc(4'he, 4'd9, 4'd0, 4'd0), "marker, skipped if taken");
	endtask

	task automatic build_program();
		int k;
		add_rnd_byte(4'hb, 4'd1);
		add_rnd_byte(4'ha, 4'd1);
		add_rnd_byte(4'hb, 4'd2);
		add_rnd_byte(4'ha, 4'd2);
		// the eight alu ops
		add_row(enc(4'h0, 4'd10, 4'd1, 4'd2), "add");
		add_row(enc(4'h1, 4'd11, 4'd1, 4'd2), "sub");
		add_row(enc(4'h2, 4'd12, 4'd1, 4'd2), "xor");
		add_row(enc(4'h3, 4'd13, 4'd1, 4'd2), "and");
		add_row(enc(4'h4, 4'd14, 4'd1, 4'd5), "sll by 5");
		add_row(enc(4'h5, 4'd15, 4'd1, 4'd3), "sra by 3");
		add_row(enc(4'h6, 4'd10, 4'd2, 4'd7), "ror by 7");
		add_row(enc(4'h7, 4'd11, 4'd1, 4'd2), "or");
		add_row(enc(4'h0, 4'd0, 4'd1, 4'd2), "add into r0");
		add_row(enc(4'h0, 4'd12, 4'd0, 4'd1), "r0 + r1");
		// store and load around base 0x20
		set_reg(4'd5, 16'h0020);
		add_row(enc(4'h9, 4'd1, 4'd5, 4'd2), "sw r1 at base+4");
		add_row(enc(4'h9, 4'd2, 4'd5, 4'hf), "sw r2 at base-2");
		add_row(enc(4'h8, 4'd13, 4'd5, 4'd2), "lw from base+4");
		add_row(enc(4'h8, 4'd14, 4'd5, 4'hf), "lw from base-2");
		set_reg(4'd3, 16'h7fff);
		set_reg(4'd4, 16'h0001);
		// z=1 v=0 n=0
		add_row(enc(4'h1, 4'd6, 4'd1, 4'd1), "sub equal");
		add_branch(3'd1, "eq taken");
		add_branch(3'd4, "ge taken");
		add_branch(3'd5, "le taken");
		add_branch(3'd7, "al taken");
		add_branch(3'd0, "ne not taken");
		add_branch(3'd2, "gt not taken");
		add_branch(3'd3, "lt not taken");
		add_branch(3'd6, "ov not taken");
		// z=0 v=1 n=1
		add_row(enc(4'h0, 4'd7, 4'd3, 4'd4), "add overflow");
		add_branch(3'd0, "ne taken");
		add_branch(3'd3, "lt taken");
		add_branch(3'd6, "ov taken");
		add_branch(3'd1, "eq not taken");
		add_branch(3'd4, "ge not taken");
		// xor sets z only, v and n survive
		add_row(enc(4'h2, 4'd8, 4'd3, 4'd3), "xor to zero");
		add_branch(3'd3, "lt taken after xor");
		add_branch(3'd6, "ov taken after xor");
		add_branch(3'd0, "ne not taken after xor");
		// z=0 v=0 n=0
		add_row(enc(4'h0, 4'd7, 4'd4, 4'd4), "add small");
		add_branch(3'd2, "gt taken");
		add_branch(3'd5, "le not taken");
		// register branch
		add_row(enc(4'h1, 4'd8, 4'd4, 4'd4), "sub equal");
		k = prog_q.size();
		set_reg(4'd6, 16'((k + 5) * 2));
		add_row(enc(4'hd, 4'd0, 4'd6, 4'd0), "br ne not taken");
		add_row(enc(4'hd, 4'he, 4'd6, 4'd0), "br al taken");
		add_row(enc(4'he, 4'd9, 4'd0, 4'd0), "marker, skipped");
		add_row(enc(4'he, 4'd10, 4'd0, 4'd0), "pcs at br target");
		add_row(enc(4'hf, 4'd0, 4'd0, 4'd0), "hlt");
	endtask

	function automatic logic cond_true(input logic [2:0] c);
		case (c)
			3'd0: return !mz;
			3'd1: return mz;
			3'd2: return !mz && !mn;
			3'd3: return mn;
			3'd4: return mz || !mn;
			3'd5: return mz || mn;
			3'd6: return mv;
			default: return 1'b1;
		endcase
	endfunction

	// executes the instruction at m_pc and predicts its retire record
	task automatic model_step(output cpu_pkg::retire_t exp, output bit halt);
		logic [15:0] w;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] res;
		logic [15:0] addr;
		logic [15:0] npc;
		logic [3:0]  op;
		logic [3:0]  rd;
		logic [3:0]  rs;
		logic [3:0]  rt;
		logic [8:0]  off;
		int          s;
		w = prog_q[m_pc >> 1];
		{op, rd, rs, rt} = w;
		exp = '0;
		exp.valid = 1'b1;
		exp.pc = m_pc;
		exp.rd = rd;
		halt = 1'b0;
		res = '0;
		npc = m_pc + 16'd2;
		if (op < 4'h8) begin
			a = m_regs[rs];
			b = (op inside {4'h4, 4'h5, 4'h6}) ? {12'b0, rt} : m_regs[rt];
			case (op)
				4'h0: res = a + b;
				4'h1: res = a - b;
				4'h2: res = a ^ b;
				4'h3: res = a & b;
				4'h4: res = a << b[3:0];
				4'h5: res = $signed(a) >>> b[3:0];
				4'h6: res = (a >> b[3:0]) | (a << (16 - b[3:0]));
				default: res = a | b;
			endcase
			mz = (res == 16'd0);
			if (op <= 4'h1) begin
				// overflow when the true signed result leaves the 16-bit range
				s = (op == 4'h0) ? $signed(a) + $signed(b) : $signed(a) - $signed(b);
				mv = (s > 32767) || (s < -32768);
				mn = res[15];
			end
			exp.reg_write = 1'b1;
		end else begin
			addr = m_regs[rs] + {{11{rt[3]}}, rt, 1'b0};
			case (op)
				4'h8: begin
					res = m_mem[addr[8:1]];
					exp.reg_write = 1'b1;
				end
				4'h9: begin
					exp.mem_write = 1'b1;
					exp.mem_addr = addr;
					exp.mem_wdata = m_regs[rd];
					m_mem[addr[8:1]] = m_regs[rd];
				end
				4'ha: begin
					res = {rs, rt, m_regs[rd][7:0]};
					exp.reg_write = 1'b1;
				end
				4'hb: begin
					res = {m_regs[rd][15:8], rs, rt};
					exp.reg_write = 1'b1;
				end
				4'hc: begin
					off = {rd[0], rs, rt};
					if (cond_true(rd[3:1]))
						npc = m_pc + 16'd2 + {{6{off[8]}}, off, 1'b0};
				end
				4'hd: begin
					if (cond_true(rd[3:1]))
						npc = m_regs[rs];
				end
				4'he: begin
					res = m_pc + 16'd2;
					exp.reg_write = 1'b1;
				end
				default: begin
					halt = 1'b1;
					npc = m_pc;
				end
			endcase
		end
		exp.wdata = res;
		if (exp.reg_write && rd != 4'd0)
			m_regs[rd] = res;
		m_pc = npc;
	endtask

	task automatic check_value(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
			$display("Errors found");
			$fatal(1, "mismatch on %s", what);
		end
	endtask

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Errors found");
		$fatal(1, "run aborted");
	endtask

	// sampled 1 ns after the falling edge, where outputs are settled
	task automatic wait_retire();
		int n;
		n = 0;
		while (!retire.valid && !hlt) begin
			if (n >= TIMEOUT)
				abort_run("timed out waiting for a retire record or hlt");
			@(negedge clk);
			#1;
			n++;
		end
	endtask

	// note names the program row in every mismatch line
	task automatic compare_retire(input cpu_pkg::retire_t exp, input string note);
		check_value({note, ": retire.valid"}, retire.valid, exp.valid);
		check_value({note, ": retire.pc"}, retire.pc, exp.pc);
		check_value({note, ": retire.reg_write"}, retire.reg_write, exp.reg_write);
		if (exp.reg_write) begin
			check_value({note, ": retire.rd"}, retire.rd, exp.rd);
			check_value({note, ": retire.wdata"}, retire.wdata, exp.wdata);
		end
		check_value({note, ": retire.mem_write"}, retire.mem_write, exp.mem_write);
		if (exp.mem_write) begin
			check_value({note, ": retire.mem_addr"}, retire.mem_addr, exp.mem_addr);
			check_value({note, ": retire.mem_wdata"}, retire.mem_wdata, exp.mem_wdata);
		end
	endtask

	initial begin
		cpu_pkg::retire_t exp;
		bit               halt;
		bit               done;
		int               steps;
		logic [15:0]      hold_pc;
		rst = 1'b1;
		prog_we = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		errors = 0;
		rng = 32'ha5db680d;
		build_program();
		for (int i = 0; i < `CPU_NREGS; i++)
			m_regs[i] = '0;
		for (int i = 0; i < 2**`CPU_DMEM_AW; i++)
			m_mem[i] = '0;
		m_pc = '0;
		{mz, mv, mn} = 3'b000;
		// program load while the core is held in reset
		for (int i = 0; i < prog_q.size(); i++) begin
			@(negedge clk);
			prog_we = 1'b1;
			prog_addr = 16'(i * 2);
			prog_data = prog_q[i];
		end
		@(negedge clk);
		prog_we = 1'b0;
		repeat (2) @(negedge clk);
		#1;
		check_value("pc in reset", pc, 16'd0);
		check_value("hlt in reset", hlt, 1'b0);
		check_value("retire.valid in reset", retire.valid, 1'b0);
		@(negedge clk);
		rst = 1'b0;
		#1;
		done = 0;
		steps = 0;
		while (!done) begin
			if (steps >= MAX_STEPS)
				abort_run("program never reached hlt");
			wait_retire();
			model_step(exp, halt);
			if (halt) begin
				check_value("hlt", hlt, 1'b1);
				done = 1;
			end else begin
				compare_retire(exp, note_q[exp.pc >> 1]);
				@(negedge clk);
				#1;
			end
			steps++;
		end
		// halted core stays put with no further records
		hold_pc = pc;
		repeat (HALT_WINDOW) begin
			@(negedge clk);
			#1;
			check_value("hlt held", hlt, 1'b1);
			check_value("pc held", pc, hold_pc);
			check_value("retire.valid after hlt", retire.valid, 1'b0);
		end
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

// ==== cpu.f ====
+incdir+.
cpu_pkg.sv
word_mem.sv
reg_file.sv
alu.sv
pc_unit.sv
decoder.sv
cpu.sv
cpu_clk_gen.sv
cpu_sva.sv
cpu_tb.sv

// ==== Bender.yml ====
package:
  name: cpu

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - cpu_pkg.sv
      - word_mem.sv
      - reg_file.sv
      - alu.sv
      - pc_unit.sv
      - decoder.sv
      - cpu.sv
  - target: test
    include_dirs:
      - .
    files:
      - cpu_clk_gen.sv
      - cpu_sva.sv
      - cpu_tb.sv
